//--- design/cnn_pkg.sv
package cnn_pkg;

    localparam int ADDR_W = 32;               // byte address width into the glb

    typedef logic [7:0] weight_t;             // one packed weight byte

    // layer encoding kept from the accelerator's layer descriptor
    typedef enum logic [1:0] {
        LAYER_STANDARD  = 2'b00,              // conv, pointwise is the 1x1 case
        LAYER_DEPTHWISE = 2'b01,              // dwconv, one 3x3 kernel
        LAYER_LINEAR    = 2'b10,              // fully connected
        LAYER_POOL      = 2'b11               // no weights at all
    } layer_type_t;

    typedef enum logic [1:0] {
        LANE_0 = 2'b00,                       // bits 7:0 of the word
        LANE_1 = 2'b01,
        LANE_2 = 2'b10,
        LANE_3 = 2'b11                        // bits 31:24
    } byte_lane_t;

    // bytes to fetch for one layer, first tile only for standard conv
    function automatic int unsigned weight_count(
        input layer_type_t lt,
        input int unsigned rows,
        input int unsigned cols
    );
        case (lt)
            LAYER_STANDARD, LAYER_LINEAR: return rows * cols; // whole array
            LAYER_DEPTHWISE:              return 9;           // pe 0..8
            default:                      return 0;           // pool
        endcase
    endfunction

endpackage

//--- design/glb_rd_if.sv
interface glb_rd_if;
    import cnn_pkg::*;

    logic              rd_en;      // read strobe from the load controller
    logic [ADDR_W-1:0] byte_addr;  // byte address, word index is addr/4
    byte_lane_t        lane;       // byte within the addressed word
    weight_t           rdata;      // selected byte, one cycle after rd_en

    modport master (
        output rd_en, byte_addr, lane,
        input  rdata
    );

    modport slave (
        input  rd_en, byte_addr, lane,
        output rdata
    );
endinterface

//--- design/pe_load_if.sv
interface pe_load_if #(
    parameter int ROWS = 4,
    parameter int COLS = 4
);
    import cnn_pkg::*;

    logic [ROWS-1:0][COLS-1:0] load_en;  // one pe captures per cycle at most
    weight_t                   weight;   // byte to capture
    logic                      any_load; // or of load_en, cheap qualifier

    modport master (
        output load_en, weight, any_load
    );

    modport slave (
        input  load_en, weight, any_load
    );
endinterface

//--- design/glb_sram.sv
module glb_sram #(
    parameter int GLB_WORDS = 64
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         wr_en,
    input  logic [$clog2(GLB_WORDS)-1:0] wr_addr,
    input  logic [31:0]                  wr_data,
    glb_rd_if.slave                      rd
);
    import cnn_pkg::*;

    localparam int WA_W = $clog2(GLB_WORDS);

    logic [31:0]     mem [GLB_WORDS];  // packed weights, 4 per word
    logic [WA_W-1:0] rd_word;          // word index taken from byte address
    logic [31:0]     rd_data_word;

    assign rd_word      = rd.byte_addr[WA_W+1:2]; // drop the lane bits
    assign rd_data_word = mem[rd_word];

    // word write port, only used for preloading
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered byte select gives the one cycle read latency
    always_ff @(posedge clk) begin
        if (rd.rd_en) begin
            case (rd.lane)
                LANE_0:  rd.rdata <= rd_data_word[7:0];
                LANE_1:  rd.rdata <= rd_data_word[15:8];
                LANE_2:  rd.rdata <= rd_data_word[23:16];
                default: rd.rdata <= rd_data_word[31:24]; // lane 3
            endcase
        end
    end

    // upper address bits are ignored by the decode, so catch runaway reads
    a_rd_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd.rd_en |-> (rd.byte_addr[ADDR_W-1:2] < GLB_WORDS)
    ) else $error("glb read beyond buffer, byte addr %0h", rd.byte_addr);

endmodule

//--- design/weight_load_controller.sv
module weight_load_controller #(
    parameter int ROWS = 4,
    parameter int COLS = 4
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       load_state,
    input  cnn_pkg::layer_type_t       layer_type,
    input  logic [cnn_pkg::ADDR_W-1:0] base_addr,
    glb_rd_if.master                   glb,
    pe_load_if.master                  pe,
    output logic                       finish
);
    import cnn_pkg::*;

    localparam int CNT_W = $clog2(ROWS * COLS + 4); // counter overruns N by 3

    logic [CNT_W-1:0]  cnt;        // read index, counts every load cycle
    logic [CNT_W-1:0]  idx_d;      // cnt one cycle late, lines up with rdata
    logic              state_d;    // load_state one cycle late
    logic              ld_valid;   // rd_en one cycle late
    logic              first;      // first load-state cycle
    layer_type_t       layer_q;
    layer_type_t       layer_cur;
    logic [ADDR_W-1:0] base_q;
    logic [ADDR_W-1:0] base_cur;
    logic [CNT_W-1:0]  n_wt;       // bytes to read for this layer

    assign first     = load_state && !state_d;
    assign layer_cur = first ? layer_type : layer_q; // inputs valid in cycle 0 only
    assign base_cur  = first ? base_addr : base_q;
    assign n_wt      = CNT_W'(weight_count(layer_cur, ROWS, COLS));

    // command fields held for the rest of the load
    always_ff @(posedge clk) begin
        if (first) begin
            layer_q <= layer_type;
            base_q  <= base_addr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (load_state) begin
            cnt <= cnt + 1'b1;     // keeps running past N until state drops
        end else begin
            cnt <= '0;
        end
    end

    // delay stage matching the glb latency
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_d  <= 1'b0;
            idx_d    <= '0;
            ld_valid <= 1'b0;
        end else begin
            state_d  <= load_state;
            idx_d    <= cnt;
            ld_valid <= glb.rd_en;
        end
    end

    // delayed count hits N one cycle after the last pe capture
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            finish <= 1'b0;
        end else begin
            finish <= state_d && (idx_d == n_wt); // single pulse, idx_d keeps climbing
        end
    end

    assign glb.rd_en     = load_state && (cnt < n_wt);
    assign glb.byte_addr = base_cur + ADDR_W'(cnt);           // base + k
    assign glb.lane      = byte_lane_t'(glb.byte_addr[1:0]);  // low bits pick the byte

    // row-major decode of the delayed index
    always_comb begin
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                pe.load_en[r][c] = ld_valid && (idx_d == CNT_W'(r * COLS + c));
            end
        end
    end

    assign pe.weight   = glb.rdata;  // byte from the read issued last cycle
    assign pe.any_load = ld_valid;

    // depthwise writes pe 0..8, the array has to hold them
    initial assert (ROWS * COLS >= 9)
        else $fatal(1, "weight array of %0d pes too small for a 3x3 kernel", ROWS * COLS);

    // every valid load lands on exactly one pe of the array
    a_load_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        ld_valid |-> $onehot(pe.load_en)
    ) else $error("valid load without exactly one pe load enable");

    // sequencer must not restart a load in the cycle that flags the end
    a_no_restart: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(load_state) |-> !finish
    ) else $error("load_state rose while finish was high");

endmodule

//--- design/pe_weight_array.sv
module pe_weight_array #(
    parameter int ROWS = 4,
    parameter int COLS = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    pe_load_if.slave                pe,
    input  logic [$clog2(ROWS)-1:0] rd_row,
    input  logic [$clog2(COLS)-1:0] rd_col,
    output cnn_pkg::weight_t        rd_weight
);
    import cnn_pkg::*;

    weight_t w_q [ROWS][COLS]; // stationary weight per pe

    // each pe only moves on its own enable, others keep old weights
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < ROWS; r++) begin
                for (int c = 0; c < COLS; c++) begin
                    w_q[r][c] <= '0;
                end
            end
        end else if (pe.any_load) begin
            for (int r = 0; r < ROWS; r++) begin
                for (int c = 0; c < COLS; c++) begin
                    if (pe.load_en[r][c]) begin
                        w_q[r][c] <= pe.weight;
                    end
                end
            end
        end
    end

    assign rd_weight = w_q[rd_row][rd_col]; // combinational readback

    // qualifier is gating the whole array, so it must track the enables
    a_any_load: assert property (
        @(posedge clk) disable iff (!rst_n)
        pe.any_load == (|pe.load_en)
    ) else $error("any_load disagrees with load_en");

endmodule

//--- design/layer_sequencer.sv
module layer_sequencer (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic finish,
    output logic load_state,
    output logic busy,
    output logic done
);

    typedef enum logic {
        S_IDLE = 1'b0,
        S_LOAD = 1'b1
    } state_t;

    state_t state;
    state_t state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE:  if (start) state_nxt = S_LOAD;   // start ignored once busy
            S_LOAD:  if (finish) state_nxt = S_IDLE;
            default: state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
            done  <= 1'b0;
        end else begin
            state <= state_nxt;
            done  <= finish;       // same edge that leaves load
        end
    end

    assign load_state = (state == S_LOAD);
    assign busy       = load_state;  // only one busy phase in this path

    // a done must close a load that the controller actually finished
    a_done_after_finish: assert property (
        @(posedge clk) disable iff (!rst_n)
        done |-> !load_state && $past(finish) && $past(load_state)
    ) else $error("done without a finished load");

endmodule

//--- design/weight_subsystem_top.sv
module weight_subsystem_top #(
    parameter int ROWS      = 4,
    parameter int COLS      = 4,
    parameter int GLB_WORDS = 64
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start,
    input  cnn_pkg::layer_type_t         layer_type,
    input  logic [cnn_pkg::ADDR_W-1:0]   base_addr,
    input  logic                         glb_wr_en,
    input  logic [$clog2(GLB_WORDS)-1:0] glb_wr_addr,
    input  logic [31:0]                  glb_wr_data,
    input  logic [$clog2(ROWS)-1:0]      rd_row,
    input  logic [$clog2(COLS)-1:0]      rd_col,
    output cnn_pkg::weight_t             rd_weight,
    output logic                         busy,
    output logic                         done
);

    logic load_state;  // sequencer -> controller
    logic finish;      // controller -> sequencer

    glb_rd_if                                 glb_rd ();
    pe_load_if #(.ROWS(ROWS), .COLS(COLS))    pe_ld ();

    layer_sequencer u_seq (
        .clk(clk), .rst_n(rst_n),
        .start(start), .finish(finish),
        .load_state(load_state), .busy(busy), .done(done)
    );

    weight_load_controller #(.ROWS(ROWS), .COLS(COLS)) u_ctrl (
        .clk(clk), .rst_n(rst_n),
        .load_state(load_state),
        .layer_type(layer_type),    // sampled in the first load cycle
        .base_addr(base_addr),
        .glb(glb_rd.master),
        .pe(pe_ld.master),
        .finish(finish)
    );

    glb_sram #(.GLB_WORDS(GLB_WORDS)) u_glb (
        .clk(clk), .rst_n(rst_n),
        .wr_en(glb_wr_en), .wr_addr(glb_wr_addr), .wr_data(glb_wr_data),
        .rd(glb_rd.slave)
    );

    pe_weight_array #(.ROWS(ROWS), .COLS(COLS)) u_pe (
        .clk(clk), .rst_n(rst_n),
        .pe(pe_ld.slave),
        .rd_row(rd_row), .rd_col(rd_col),
        .rd_weight(rd_weight)
    );

endmodule

//--- testbench/tb_weight_subsystem.sv
module tb_weight_subsystem;
    timeunit 1ns;
    timeprecision 100ps;
    import cnn_pkg::*;

    localparam int ROWS      = 4;
    localparam int COLS      = 4;
    localparam int GLB_WORDS = 64;

    logic                         clk;
    logic                         rst_n;
    logic                         start;
    layer_type_t                  layer_type;
    logic [ADDR_W-1:0]            base_addr;
    logic                         glb_wr_en;
    logic [$clog2(GLB_WORDS)-1:0] glb_wr_addr;
    logic [31:0]                  glb_wr_data;
    logic [$clog2(ROWS)-1:0]      rd_row;
    logic [$clog2(COLS)-1:0]      rd_col;
    weight_t                      rd_weight;
    logic                         busy;
    logic                         done;

    logic [31:0] w_addr[$];     // glb preload, word index
    logic [31:0] w_data[$];
    string       t_name[$];     // one entry per test command
    int          t_layer[$];
    logic [31:0] t_base[$];
    int          t_restart[$];  // nonzero: pulse a second start while busy
    int          e_test[$];     // expected rows, tagged with their test
    int          e_row[$];
    logic [31:0] e_val[$];      // col 0 in the low byte

    int cycles = 0;
    int limit  = 0;             // 0 until the trace is read
    int errors = 0;
    int passed = 0;
    int failed = 0;

    weight_subsystem_top #(.ROWS(ROWS), .COLS(COLS), .GLB_WORDS(GLB_WORDS)) dut (
        .clk(clk), .rst_n(rst_n),
        .start(start), .layer_type(layer_type), .base_addr(base_addr),
        .glb_wr_en(glb_wr_en), .glb_wr_addr(glb_wr_addr), .glb_wr_data(glb_wr_data),
        .rd_row(rd_row), .rd_col(rd_col), .rd_weight(rd_weight),
        .busy(busy), .done(done)
    );

    always #2 clk = ~clk;  // 4 ns period

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: run went past its limit of %0d cycles", limit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // bytes loaded per layer: 0 std, 1 dw, 2 linear, 3 pool
    function automatic int loads_for_layer(input int lt);
        case (lt)
            1:       return 9;            // one 3x3 kernel
            3:       return 0;            // pool has no weights
            default: return ROWS * COLS;  // first tile fills the array
        endcase
    endfunction

    task automatic read_trace();
        int          fd;
        int          n;
        string       kind;
        string       name;
        string       line;
        int          lt;
        int          rs;
        int          r;
        logic [31:0] a;
        logic [31:0] d;
        fd = $fopen("testbench/weight_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file");
            errors++;
        end else begin
            while ($fscanf(fd, "%s", kind) == 1) begin
                if (kind == "W") begin
                    n = $fscanf(fd, "%h %h", a, d);
                    w_addr.push_back(a);
                    w_data.push_back(d);
                end else if (kind == "T") begin
                    n = $fscanf(fd, "%s %d %h %d", name, lt, a, rs);
                    t_name.push_back(name);
                    t_layer.push_back(lt);
                    t_base.push_back(a);
                    t_restart.push_back(rs);
                end else if (kind == "E") begin
                    n = $fscanf(fd, "%d %h", r, d);
                    e_test.push_back(t_name.size() - 1);  // belongs to last T
                    e_row.push_back(r);
                    e_val.push_back(d);
                end else begin
                    n = $fgets(line, fd);  // comment line
                end
            end
            $fclose(fd);
        end
    endtask

    // read one pe row back through the combinational port
    task automatic check_row(input string name, input int row, input logic [31:0] exp_row);
        weight_t exp_w;
        for (int c = 0; c < COLS; c++) begin
            @(negedge clk);
            rd_row = row[$clog2(ROWS)-1:0];
            rd_col = c[$clog2(COLS)-1:0];
            exp_w  = exp_row[8*c +: 8];
            @(posedge clk);                // weights are static here
            assert (rd_weight == exp_w) else begin
                $display("error: %s pe[%0d][%0d] expected %02h actual %02h",
                         name, row, c, exp_w, rd_weight);
                errors++;
            end
        end
    endtask

    task automatic run_test(input int i);
        int n;
        int lat;
        int extra;
        n = loads_for_layer(t_layer[i]);
        @(negedge clk);
        layer_type = layer_type_t'(t_layer[i][1:0]);
        base_addr  = t_base[i];
        start      = 1'b1;
        @(posedge clk);                    // start edge
        lat = 0;
        @(negedge clk);
        start = 1'b0;
        while (!done) begin
            @(negedge clk);
            lat++;                         // rising edges since start
            if (t_restart[i] != 0 && lat == 2) begin
                assert (busy) else begin
                    $display("second start of %s was not issued while busy", t_name[i]);
                    errors++;
                end
                start     = 1'b1;          // must be dropped by the sequencer
                base_addr = t_base[i] + 32'd4;
            end else begin
                start = 1'b0;
            end
        end
        assert (lat == n + 3) else begin
            $display("error: %s done latency expected %0d actual %0d", t_name[i], n + 3, lat);
            errors++;
        end
        if (t_restart[i] != 0) begin
            extra = 0;
            repeat (n + 4) begin
                @(negedge clk);
                if (done) extra++;
            end
            assert (extra == 0) else begin
                $display("error: %s extra done pulses expected 0 actual %0d", t_name[i], extra);
                errors++;
            end
        end
    endtask

    task automatic report(input string name, input int err0);
        if (errors == err0) begin
            passed++;
            $display("test %-18s ok", name);
        end else begin
            failed++;
            $display("test %-18s failed with %0d errors", name, errors - err0);
        end
    endtask

    initial begin
        int gap;
        int err0;
        clk         = 1'b0;
        rst_n       = 1'b0;
        start       = 1'b0;
        layer_type  = LAYER_STANDARD;
        base_addr   = '0;
        glb_wr_en   = 1'b0;
        glb_wr_addr = '0;
        glb_wr_data = '0;
        rd_row      = '0;
        rd_col      = '0;
        void'($urandom(32'hcf07a83e));
        read_trace();
        limit = 40 + w_addr.size() + ROWS * COLS + e_row.size() * COLS;
        foreach (t_name[i]) begin
            limit += 2 * loads_for_layer(t_layer[i]) + 12;  // gap, load, restart watch
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        err0 = errors;
        assert (!busy && !done) else begin
            $display("busy or done is high right after reset");
            errors++;
        end
        for (int r = 0; r < ROWS; r++) begin
            check_row("after_reset", r, 32'h0);
        end
        report("after_reset", err0);

        foreach (w_addr[k]) begin
            @(negedge clk);
            glb_wr_en   = 1'b1;
            glb_wr_addr = w_addr[k][$clog2(GLB_WORDS)-1:0];
            glb_wr_data = w_data[k];
        end
        @(negedge clk);
        glb_wr_en = 1'b0;

        if (t_name.size() == 0) begin
            $display("the trace holds no test commands");
            errors++;
        end
        foreach (t_name[i]) begin
            err0 = errors;
            gap  = $urandom % 4;           // idle cycles before the start
            repeat (gap) @(negedge clk);
            run_test(i);
            foreach (e_test[j]) begin
                if (e_test[j] == i) begin
                    check_row(t_name[i], e_row[j], e_val[j]);
                end
            end
            report(t_name[i], err0);
        end

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 passed + failed, passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- testbench/weight_trace.txt
# W word data | T name layer base restart | E row weights
# layer 0 std 1 dw 2 linear 3 pool, E packs col 0 into the low byte
W 00 13121110
W 01 17161514
W 02 1b1a1918
W 03 1f1e1d1c
W 04 23222120
W 05 27262524
W 06 2b2a2928
W 07 2f2e2d2c
T std_aligned 0 00000000 0
E 0 13121110
E 1 17161514
E 2 1b1a1918
E 3 1f1e1d1c
T linear_unaligned 2 00000003 0
E 0 16151413
E 1 1a191817
E 2 1e1d1c1b
E 3 2221201f
T dw_partial 1 00000014 0
E 0 27262524
E 1 2b2a2928
E 2 1e1d1c2c
E 3 2221201f
T pool_noload 3 00000000 0
E 0 27262524
E 1 2b2a2928
E 2 1e1d1c2c
E 3 2221201f
T restart_ignored 0 00000010 1
E 0 23222120
E 1 27262524
E 2 2b2a2928
E 3 2f2e2d2c

//--- flist.f
design/cnn_pkg.sv
design/glb_rd_if.sv
design/pe_load_if.sv
design/glb_sram.sv
design/weight_load_controller.sv
design/pe_weight_array.sv
design/layer_sequencer.sv
design/weight_subsystem_top.sv
testbench/tb_weight_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# build and run the weight subsystem testbench with verilator, from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_weight_subsystem -f flist.f -o sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^TEST RESULT: PASS$"; then
    exit 0
fi
exit 1
